/* rtl/im2col_pkg.sv */
// shared types and constants for the im2col SPC, one DMA channel on a 32-bit bus
// host word layouts: CFG_SIZE is {d2, d1}, CFG_PAD is {top, bottom, left, right},
// CFG_MODE holds irq_en [8], dtype [5:4] and log_stride [3:0], CFG_NUM_CH holds [7:0]
package im2col_pkg;

  typedef logic [31:0] word_t;     // data word or byte address
  typedef logic [3:0]  cfg_addr_t; // host register index
  typedef logic [7:0]  ch_cnt_t;   // channel count or index
  typedef logic [1:0]  dtype_t;    // 0 is 32-bit, 1 is 16-bit, 2 is 8-bit

  ////////////////////////////////////////////////////////////
  // host register map
  ////////////////////////////////////////////////////////////
  localparam cfg_addr_t CFG_IN_BASE    = 4'd0;
  localparam cfg_addr_t CFG_OUT_BASE   = 4'd1;
  localparam cfg_addr_t CFG_IN_STRIDE  = 4'd2;
  localparam cfg_addr_t CFG_OUT_STRIDE = 4'd3;
  localparam cfg_addr_t CFG_SIZE       = 4'd4;
  localparam cfg_addr_t CFG_PAD        = 4'd5;
  localparam cfg_addr_t CFG_MODE       = 4'd6;
  localparam cfg_addr_t CFG_IRQ_CLR    = 4'd7;
  localparam cfg_addr_t CFG_NUM_CH     = 4'd8; // a write here starts a run

  typedef struct packed {
    logic [7:0] top;
    logic [7:0] bottom;
    logic [7:0] left;
    logic [7:0] right;
  } pad_t;

  typedef struct packed {
    word_t       in_base;
    word_t       out_base;
    word_t       in_stride;
    word_t       out_stride;
    logic [15:0] size_d1;
    logic [15:0] size_d2;
    pad_t        pad;
    logic [3:0]  log_stride;
    dtype_t      dtype;
    logic        irq_en;
    ch_cnt_t     num_ch;
  } im2col_cfg_t;

  typedef struct packed {
    word_t src_ptr;
    word_t dst_ptr;
    logic  last;     // final channel of the run
  } dma_desc_t;

  typedef struct packed {
    word_t addr;
    word_t data;
  } reg_wr_t;

  ////////////////////////////////////////////////////////////
  // DMA channel register offsets, listed in write order
  ////////////////////////////////////////////////////////////
  localparam word_t DMA_DIM_OFS        = 32'h40;
  localparam word_t DMA_SRC_TYPE_OFS   = 32'h34;
  localparam word_t DMA_DST_TYPE_OFS   = 32'h38;
  localparam word_t DMA_PAD_TOP_OFS    = 32'h48;
  localparam word_t DMA_PAD_BOTTOM_OFS = 32'h4c;
  localparam word_t DMA_PAD_LEFT_OFS   = 32'h50;
  localparam word_t DMA_PAD_RIGHT_OFS  = 32'h54;
  localparam word_t DMA_SRC_PTR_OFS    = 32'h00;
  localparam word_t DMA_DST_PTR_OFS    = 32'h04;
  localparam word_t DMA_SRC_INC_D1_OFS = 32'h18;
  localparam word_t DMA_DST_INC_D1_OFS = 32'h20;
  localparam word_t DMA_SIZE_D2_OFS    = 32'h10;
  localparam word_t DMA_SIZE_D1_OFS    = 32'h0c;

  // write states run in encoding order, the loader steps through them by increment
  typedef enum logic [3:0] {
    LD_IDLE,
    LD_DIM,
    LD_SRC_TYPE,
    LD_DST_TYPE,
    LD_PAD_TOP,
    LD_PAD_BOTTOM,
    LD_PAD_LEFT,
    LD_PAD_RIGHT,
    LD_SRC_PTR,
    LD_DST_PTR,
    LD_SRC_INC_D1,
    LD_DST_INC_D1,
    LD_SIZE_D2,
    LD_SIZE_D1,
    LD_WAIT_DONE
  } load_state_e;

endpackage

/* rtl/im2col_cfg_regs.sv */
// host configuration registers with start, busy and sticky interrupt flags
// the configuration must not change while busy_o is high
// a CFG_NUM_CH write while a run is pending or active is dropped entirely
`timescale 1ns/1ps

module im2col_cfg_regs
  import im2col_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cfg_we_i,
  input  cfg_addr_t   cfg_addr_i,
  input  word_t       cfg_wdata_i,
  input  logic        run_done_i,
  output im2col_cfg_t cfg_o,
  output logic        start_o,
  output logic        busy_o,
  output logic        irq_o
);

  im2col_cfg_t cfg_q;
  logic        start_q;
  logic        busy_q;
  logic        irq_q;
  logic        run_req;

  // a new run is only accepted while idle and no start is in flight
  assign run_req = cfg_we_i && (cfg_addr_i == CFG_NUM_CH) && !busy_q && !start_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CFG_IN_BASE:    cfg_q.in_base    <= cfg_wdata_i;
        CFG_OUT_BASE:   cfg_q.out_base   <= cfg_wdata_i;
        CFG_IN_STRIDE:  cfg_q.in_stride  <= cfg_wdata_i;
        CFG_OUT_STRIDE: cfg_q.out_stride <= cfg_wdata_i;
        CFG_SIZE: begin
          cfg_q.size_d1 <= cfg_wdata_i[15:0];
          cfg_q.size_d2 <= cfg_wdata_i[31:16];
        end
        CFG_PAD:        cfg_q.pad <= pad_t'(cfg_wdata_i);
        CFG_MODE: begin
          cfg_q.log_stride <= cfg_wdata_i[3:0];
          cfg_q.dtype      <= cfg_wdata_i[5:4];
          cfg_q.irq_en     <= cfg_wdata_i[8];
        end
        CFG_NUM_CH: begin
          if (run_req) cfg_q.num_ch <= cfg_wdata_i[7:0]; // count held for the whole run
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      start_q <= run_req;
      if (run_done_i) begin
        busy_q <= 1'b0;
      end else if (start_q) begin
        busy_q <= 1'b1;
      end
      if (run_done_i && cfg_q.irq_en) begin
        irq_q <= 1'b1;                          // sticky until the host clears it
      end else if (cfg_we_i && (cfg_addr_i == CFG_IRQ_CLR)) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign cfg_o   = cfg_q;
  assign start_o = start_q;
  assign busy_o  = busy_q;
  assign irq_o   = irq_q;

endmodule

/* rtl/im2col_desc_gen.sv */
// generates one DMA descriptor per input channel, num_ch must be at least 1
// pointers advance by the configured strides, so channel i gets base + i * stride
`timescale 1ns/1ps

module im2col_desc_gen
  import im2col_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  im2col_cfg_t cfg_i,
  input  logic        start_i,
  input  logic        full_i,
  output dma_desc_t   desc_o,
  output logic        push_o
);

  logic    active_q;
  ch_cnt_t ch_q;
  word_t   src_q;
  word_t   dst_q;
  logic    last_ch;

  assign last_ch = (ch_q == cfg_i.num_ch - 8'd1);
  assign push_o  = active_q && !full_i;   // stall while the FIFO is full
  assign desc_o  = '{src_ptr: src_q, dst_ptr: dst_q, last: last_ch};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      ch_q     <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      ch_q     <= '0;
    end else if (push_o) begin
      ch_q <= ch_q + 8'd1;
      if (last_ch) active_q <= 1'b0;      // run fully queued
    end
  end

  // running source and destination pointers
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      src_q <= cfg_i.in_base;
      dst_q <= cfg_i.out_base;
    end else if (push_o) begin
      src_q <= src_q + cfg_i.in_stride;
      dst_q <= dst_q + cfg_i.out_stride;
    end
  end

  // a zero or changed num_ch would run the count past the last channel
  a_push_within_run: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_o |-> (ch_q < cfg_i.num_ch)
  ) else $error("descriptor pushed beyond the last channel of the run");

endmodule

/* rtl/im2col_desc_fifo.sv */
// fall-through descriptor FIFO, the head shows the incoming push when empty
// a push into a full FIFO is dropped, FIFO_DEPTH must be at least 1
`timescale 1ns/1ps

module im2col_desc_fifo
  import im2col_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  dma_desc_t desc_i,
  input  logic      push_i,
  input  logic      pop_i,
  output dma_desc_t desc_o,
  output logic      full_o,
  output logic      empty_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  dma_desc_t        mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] usage_q;
  logic             bypass;
  logic             do_write;
  logic             do_read;

  assign bypass   = (usage_q == '0);
  assign empty_o  = bypass && !push_i;
  assign full_o   = (usage_q == CNT_W'(FIFO_DEPTH));
  assign desc_o   = bypass ? desc_i : mem_q[rd_ptr_q];
  assign do_write = push_i && !full_o && !(bypass && pop_i); // push and pop on empty pass through
  assign do_read  = pop_i && !bypass;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_read) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_write && !do_read) begin
        usage_q <= usage_q + 1'b1;
      end else if (do_read && !do_write) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) mem_q[wr_ptr_q] <= desc_i;
  end

  a_no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o
  ) else $error("descriptor popped from an empty FIFO");

endmodule

/* rtl/im2col_dma_loader.sv */
// programs the single DMA channel from the FIFO head, one register write per state
// the channel counts as busy from the issue of the size d1 write until dma_done_i
// the type prefix is written only for the first transaction after start
`timescale 1ns/1ps

module im2col_dma_loader
  import im2col_pkg::*;
#(
  parameter word_t DMA_BASE = 32'h0000_0000
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  im2col_cfg_t cfg_i,
  input  logic        start_i,
  input  dma_desc_t   desc_i,
  input  logic        empty_i,
  input  logic        wr_done_i,
  input  logic        dma_done_i,
  output logic        pop_o,
  output reg_wr_t     wr_o,
  output logic        wr_start_o,
  output logic        run_done_o
);

  load_state_e state_q;
  logic        wr_pending_q;  // a write is with the master
  logic        first_done_q;  // type prefix already written this run
  logic        ch_free_q;
  logic        last_q;
  logic        run_done_q;
  logic        leave_idle;
  logic        write_state;
  word_t       elem_bytes;
  word_t       wr_ofs;
  word_t       wr_data;

  assign leave_idle  = (state_q == LD_IDLE) && !empty_i && ch_free_q;
  assign write_state = (state_q != LD_IDLE) && (state_q != LD_WAIT_DONE);
  assign wr_start_o  = write_state && !wr_pending_q;
  assign pop_o       = (state_q == LD_SIZE_D1) && wr_done_i;
  assign elem_bytes  = 32'd4 >> cfg_i.dtype;
  assign wr_o        = '{addr: DMA_BASE + wr_ofs, data: wr_data};
  assign run_done_o  = run_done_q;

  ////////////////////////////////////////////////////////////
  // register address and data per state
  ////////////////////////////////////////////////////////////
  always_comb begin
    wr_ofs  = '0;
    wr_data = '0;
    case (state_q)
      LD_DIM:        begin wr_ofs = DMA_DIM_OFS;        wr_data = 32'd1;                 end
      LD_SRC_TYPE:   begin wr_ofs = DMA_SRC_TYPE_OFS;   wr_data = {30'd0, cfg_i.dtype};  end
      LD_DST_TYPE:   begin wr_ofs = DMA_DST_TYPE_OFS;   wr_data = {30'd0, cfg_i.dtype};  end
      LD_PAD_TOP:    begin wr_ofs = DMA_PAD_TOP_OFS;    wr_data = {24'd0, cfg_i.pad.top}; end
      LD_PAD_BOTTOM: begin wr_ofs = DMA_PAD_BOTTOM_OFS; wr_data = {24'd0, cfg_i.pad.bottom}; end
      LD_PAD_LEFT:   begin wr_ofs = DMA_PAD_LEFT_OFS;   wr_data = {24'd0, cfg_i.pad.left};  end
      LD_PAD_RIGHT:  begin wr_ofs = DMA_PAD_RIGHT_OFS;  wr_data = {24'd0, cfg_i.pad.right}; end
      LD_SRC_PTR:    begin wr_ofs = DMA_SRC_PTR_OFS;    wr_data = desc_i.src_ptr;        end
      LD_DST_PTR:    begin wr_ofs = DMA_DST_PTR_OFS;    wr_data = desc_i.dst_ptr;        end
      LD_SRC_INC_D1: begin
        wr_ofs  = DMA_SRC_INC_D1_OFS;
        wr_data = elem_bytes << cfg_i.log_stride;  // stride in elements times element size
      end
      LD_DST_INC_D1: begin wr_ofs = DMA_DST_INC_D1_OFS; wr_data = elem_bytes;            end
      LD_SIZE_D2:    begin wr_ofs = DMA_SIZE_D2_OFS;    wr_data = {16'd0, cfg_i.size_d2}; end
      LD_SIZE_D1:    begin wr_ofs = DMA_SIZE_D1_OFS;    wr_data = {16'd0, cfg_i.size_d1}; end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= LD_IDLE;
      wr_pending_q <= 1'b0;
    end else begin
      if (wr_start_o) begin
        wr_pending_q <= 1'b1;
      end else if (wr_done_i) begin
        wr_pending_q <= 1'b0;
      end
      case (state_q)
        LD_IDLE: begin
          if (leave_idle) state_q <= first_done_q ? LD_PAD_TOP : LD_DIM;
        end
        LD_WAIT_DONE: begin
          if (ch_free_q) state_q <= LD_IDLE;
        end
        default: begin
          if (wr_done_i) state_q <= load_state_e'(state_q + 4'd1); // size d1 steps to wait
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // channel tracking and run completion
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_done_q <= 1'b0;
      ch_free_q    <= 1'b1;
      last_q       <= 1'b0;
      run_done_q   <= 1'b0;
    end else begin
      if (start_i) begin
        first_done_q <= 1'b0;
      end else if (leave_idle) begin
        first_done_q <= 1'b1;
      end
      if (dma_done_i) begin
        ch_free_q <= 1'b1;
      end else if (wr_start_o && (state_q == LD_SIZE_D1)) begin
        ch_free_q <= 1'b0;                // size d1 launches the transfer
        last_q    <= desc_i.last;
      end
      run_done_q <= dma_done_i && !ch_free_q && last_q;
    end
  end

  // the master only reports done for the write it holds
  a_done_for_pending_write: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_done_i |-> wr_pending_q
  ) else $error("register write done reported with no write outstanding");

endmodule

/* rtl/im2col_reg_master.sv */
// four-phase req/ack write master, holds one write at a time
// wr_start_i is only accepted while the master is idle
`timescale 1ns/1ps

module im2col_reg_master
  import im2col_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  reg_wr_t wr_i,
  input  logic    wr_start_i,
  input  logic    dma_ack_i,
  output reg_wr_t dma_wr_o,
  output logic    dma_req_o,
  output logic    wr_done_o
);

  typedef enum logic [1:0] {
    MST_IDLE,
    MST_REQ,
    MST_REL
  } mst_state_e;

  mst_state_e state_q;
  reg_wr_t    wr_q;
  logic       done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MST_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        MST_IDLE: if (wr_start_i) state_q <= MST_REQ;
        MST_REQ:  if (dma_ack_i) state_q <= MST_REL;   // slave took the write, drop req
        MST_REL: begin
          if (!dma_ack_i) begin                         // handshake back to rest
            state_q <= MST_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= MST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == MST_IDLE) && wr_start_i) wr_q <= wr_i;
  end

  assign dma_req_o = (state_q == MST_REQ);
  assign dma_wr_o  = wr_q;
  assign wr_done_o = done_q;

  // a start outside idle would be lost while a write is outstanding
  a_start_when_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_start_i |-> (state_q == MST_IDLE)
  ) else $error("register write started while another is outstanding");

endmodule

/* rtl/im2col_spc.sv */
// im2col smart peripheral controller driving one DMA channel
// DMA_BASE is the byte address of that channel's register block
`timescale 1ns/1ps

module im2col_spc
  import im2col_pkg::*;
#(
  parameter word_t DMA_BASE   = 32'h0000_1000,
  parameter int    FIFO_DEPTH = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  word_t     cfg_wdata_i,
  input  logic      dma_ack_i,
  input  logic      dma_done_i,
  output reg_wr_t   dma_wr_o,
  output logic      dma_req_o,
  output logic      busy_o,
  output logic      irq_o
);

  im2col_cfg_t cfg;
  logic        start;
  logic        run_done;
  dma_desc_t   gen_desc;
  logic        push;
  logic        full;
  dma_desc_t   head_desc;
  logic        empty;
  logic        pop;
  reg_wr_t     wr;
  logic        wr_start;
  logic        wr_done;

  im2col_cfg_regs u_cfg_regs (
    .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .run_done_i (run_done),
    .cfg_o      (cfg),
    .start_o    (start),
    .busy_o,
    .irq_o
  );

  im2col_desc_gen u_desc_gen (
    .clk_i, .rst_ni,
    .cfg_i   (cfg),
    .start_i (start),
    .full_i  (full),
    .desc_o  (gen_desc),
    .push_o  (push)
  );

  im2col_desc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_desc_fifo (
    .clk_i, .rst_ni,
    .desc_i  (gen_desc),
    .push_i  (push),
    .pop_i   (pop),
    .desc_o  (head_desc),
    .full_o  (full),
    .empty_o (empty)
  );

  im2col_dma_loader #(.DMA_BASE(DMA_BASE)) u_dma_loader (
    .clk_i, .rst_ni,
    .cfg_i      (cfg),
    .start_i    (start),
    .desc_i     (head_desc),
    .empty_i    (empty),
    .wr_done_i  (wr_done),
    .dma_done_i,
    .pop_o      (pop),
    .wr_o       (wr),
    .wr_start_o (wr_start),
    .run_done_o (run_done)
  );

  im2col_reg_master u_reg_master (
    .clk_i, .rst_ni,
    .wr_i       (wr),
    .wr_start_i (wr_start),
    .dma_ack_i,
    .dma_wr_o,
    .dma_req_o,
    .wr_done_o  (wr_done)
  );

endmodule

/* test/tb_im2col_spc.sv */
// directed testbench for the im2col SPC with a four-phase DMA register slave model
// the slave acks after 0 to 3 cycles and pulses dma_done_i a few cycles after size d1
// expected DMA writes are rebuilt from the configuration, one channel per descriptor
`timescale 1ns/1ps

module tb_im2col_spc
  import im2col_pkg::*;
;

  localparam word_t DMA_BASE        = 32'h0000_2000;
  localparam int    RUN_TIMEOUT     = 2000;   // cycles allowed for busy_o to change
  // about 8 runs of up to 6 channels, 13 writes of at most 12 cycles each, with margin
  localparam int    WATCHDOG_CYCLES = 20000;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      cfg_we;
  cfg_addr_t cfg_addr;
  word_t     cfg_wdata;
  logic      dma_ack = 1'b0;
  logic      dma_done = 1'b0;
  reg_wr_t   dma_wr;
  logic      dma_req;
  logic      busy;
  logic      irq;

  word_t   seed = 32'hf9a783a3;
  reg_wr_t wr_log [$];   // writes as the slave accepted them
  reg_wr_t exp_q [$];
  int      errors = 0;
  int      tests_run = 0;
  int      tests_failed = 0;
  int      done_cnt;
  int      ack_wait;
  int      done_wait;
  logic    xfer_pending;
  logic    req_prev;
  reg_wr_t wr_prev;
  word_t   rnd;

  im2col_spc #(.DMA_BASE(DMA_BASE), .FIFO_DEPTH(4)) u_im2col_spc (
    .clk_i(clk), .rst_ni(rst_n), .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr),
    .cfg_wdata_i(cfg_wdata), .dma_ack_i(dma_ack), .dma_done_i(dma_done),
    .dma_wr_o(dma_wr), .dma_req_o(dma_req), .busy_o(busy), .irq_o(irq)
  );

  always #50 clk = ~clk;

  function automatic word_t next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  task automatic check_wr(input string name, input reg_wr_t got, input reg_wr_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got addr %h data %h, expected addr %h data %h",
               $time, name, got.addr, got.data, exp.addr, exp.data);
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // DMA slave model and bus monitor
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!rst_n) begin
      dma_ack      = 1'b0;
      dma_done     = 1'b0;
      req_prev     = 1'b0;
      ack_wait     = 0;
      done_wait    = 0;
      xfer_pending = 1'b0;
    end else begin
      if (dma_req && !req_prev) begin
        if (dma_ack) begin
          errors++;
          $display("ERROR at %0t ns: dma_req_o rose while dma_ack_i was still high", $time);
        end
        if (xfer_pending) begin
          errors++;
          $display("ERROR at %0t ns: new DMA write before dma_done_i of the last transfer",
                   $time);
        end
      end
      if (dma_req && req_prev) check_wr("dma_wr_o under req", dma_wr, wr_prev);
      req_prev = dma_req;
      wr_prev  = dma_wr;
      if (!dma_ack) begin
        if (dma_req && ack_wait == 0) begin
          dma_ack = 1'b1;
          wr_log.push_back(dma_wr);
          if (dma_wr.addr == DMA_BASE + DMA_SIZE_D1_OFS) begin
            xfer_pending = 1'b1;             // size d1 launches the transfer
            rnd          = next_rand();
            done_wait    = 3 + int'(rnd[17:16]);
          end
          rnd      = next_rand();
          ack_wait = int'(rnd[17:16]);
        end else if (dma_req) begin
          ack_wait--;
        end
      end else if (!dma_req) begin
        dma_ack = 1'b0;                      // fourth phase
      end
      dma_done = 1'b0;
      if (done_wait != 0) begin
        done_wait--;
        if (done_wait == 0) begin
          dma_done     = 1'b1;
          xfer_pending = 1'b0;
          done_cnt++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // expected write list and host helpers
  ////////////////////////////////////////////////////////////
  function automatic void expect_wr(input word_t ofs, input word_t data);
    reg_wr_t w;
    w.addr = DMA_BASE + ofs;
    w.data = data;
    exp_q.push_back(w);
  endfunction

  function automatic void build_expected(input im2col_cfg_t c);
    int    ch;
    word_t bytes;
    case (c.dtype)
      2'd0:    bytes = 32'd4;
      2'd1:    bytes = 32'd2;
      default: bytes = 32'd1;
    endcase
    for (ch = 0; ch < int'(c.num_ch); ch++) begin
      if (ch == 0) begin                     // type prefix only on the first transfer
        expect_wr(DMA_DIM_OFS, 32'd1);
        expect_wr(DMA_SRC_TYPE_OFS, {30'd0, c.dtype});
        expect_wr(DMA_DST_TYPE_OFS, {30'd0, c.dtype});
      end
      expect_wr(DMA_PAD_TOP_OFS, {24'd0, c.pad.top});
      expect_wr(DMA_PAD_BOTTOM_OFS, {24'd0, c.pad.bottom});
      expect_wr(DMA_PAD_LEFT_OFS, {24'd0, c.pad.left});
      expect_wr(DMA_PAD_RIGHT_OFS, {24'd0, c.pad.right});
      expect_wr(DMA_SRC_PTR_OFS, c.in_base + word_t'(ch) * c.in_stride);
      expect_wr(DMA_DST_PTR_OFS, c.out_base + word_t'(ch) * c.out_stride);
      expect_wr(DMA_SRC_INC_D1_OFS, (32'd1 << c.log_stride) * bytes);
      expect_wr(DMA_DST_INC_D1_OFS, bytes);
      expect_wr(DMA_SIZE_D2_OFS, {16'd0, c.size_d2});
      expect_wr(DMA_SIZE_D1_OFS, {16'd0, c.size_d1});
    end
  endfunction

  function automatic im2col_cfg_t base_cfg();
    im2col_cfg_t c;
    c            = '0;
    c.in_base    = 32'h8000_0000;
    c.out_base   = 32'h9000_0000;
    c.in_stride  = 32'h0000_0400;
    c.out_stride = 32'h0000_1000;
    c.size_d1    = 16'd28;
    c.size_d2    = 16'd9;
    c.pad        = '{top: 8'd1, bottom: 8'd2, left: 8'd3, right: 8'd4};
    c.num_ch     = 8'd1;
    return c;
  endfunction

  task automatic host_write(input cfg_addr_t addr, input word_t data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (busy !== level && n < RUN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy !== level) begin
      errors++;
      $display("ERROR at %0t ns: busy_o did not go to %b within %0d cycles",
               $time, level, RUN_TIMEOUT);
    end
  endtask

  task automatic start_run(input im2col_cfg_t c);
    wr_log.delete();
    exp_q.delete();
    done_cnt = 0;
    build_expected(c);
    host_write(CFG_IRQ_CLR, 32'd0);
    host_write(CFG_IN_BASE, c.in_base);
    host_write(CFG_OUT_BASE, c.out_base);
    host_write(CFG_IN_STRIDE, c.in_stride);
    host_write(CFG_OUT_STRIDE, c.out_stride);
    host_write(CFG_SIZE, {c.size_d2, c.size_d1});
    host_write(CFG_PAD, word_t'(c.pad));
    host_write(CFG_MODE, {23'd0, c.irq_en, 2'd0, c.dtype, c.log_stride});
    host_write(CFG_NUM_CH, {24'd0, c.num_ch});
  endtask

  task automatic finish_run(input im2col_cfg_t c);
    int i;
    wait_busy(1'b1);
    wait_busy(1'b0);
    // busy_o has just fallen, every transfer must be complete by now
    check_word("dma_done_i count", word_t'(done_cnt), word_t'(c.num_ch));
    check_bit("transfer pending at end", xfer_pending, 1'b0);
    check_bit("irq_o", irq, c.irq_en);
    check_word("write count", word_t'(wr_log.size()), word_t'(exp_q.size()));
    for (i = 0; i < exp_q.size() && i < wr_log.size(); i++) begin
      check_wr($sformatf("write %0d", i), wr_log[i], exp_q[i]);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic single_channel_run();
    int          e;
    im2col_cfg_t c;
    e = errors;
    check_bit("dma_req_o after reset", dma_req, 1'b0);
    check_bit("busy_o after reset", busy, 1'b0);
    check_bit("irq_o after reset", irq, 1'b0);
    c = base_cfg();
    start_run(c);
    finish_run(c);
    report_test("single channel", e);
  endtask

  task automatic multi_channel_run();
    int          e;
    im2col_cfg_t c;
    e        = errors;
    c        = base_cfg();
    c.num_ch = 8'd3;
    start_run(c);
    finish_run(c);
    report_test("multiple channels", e);
  endtask

  task automatic dtype_stride_sweep();
    int          e;
    int          d;
    im2col_cfg_t c;
    word_t       bytes;
    e = errors;
    for (d = 0; d < 3; d++) begin
      c            = base_cfg();
      c.dtype      = dtype_t'(d);
      c.log_stride = 4'd2;
      bytes        = (d == 0) ? 32'd4 : (d == 1) ? 32'd2 : 32'd1; // 4, 2 and 1 byte elements
      start_run(c);
      finish_run(c);
      if (wr_log.size() > 10) begin
        check_word("src inc d1", wr_log[9].data, 32'd4 * bytes);
        check_word("dst inc d1", wr_log[10].data, bytes);
      end
    end
    report_test("data type and stride", e);
  endtask

  task automatic random_delay_run();
    int          e;
    int          r;
    im2col_cfg_t c;
    e = errors;
    for (r = 0; r < 2; r++) begin
      c            = base_cfg();
      c.in_base    = next_rand() & 32'hffff_fffc;
      c.out_base   = next_rand() & 32'hffff_fffc;
      c.in_stride  = next_rand() & 32'h0000_fffc;
      c.out_stride = next_rand() & 32'h0000_fffc;
      c.num_ch     = (r == 0) ? 8'd6 : 8'd4;  // more channels than FIFO entries
      c.irq_en     = r[0];
      start_run(c);
      finish_run(c);
    end
    report_test("handshake under random delays", e);
  endtask

  task automatic completion_irq_run();
    int          e;
    int          count;
    im2col_cfg_t c;
    e        = errors;
    c        = base_cfg();
    c.num_ch = 8'd3;
    c.irq_en = 1'b1;
    start_run(c);
    wait_busy(1'b1);
    host_write(CFG_NUM_CH, 32'd5);           // must be dropped while busy
    finish_run(c);
    count = wr_log.size();
    repeat (20) @(negedge clk);
    check_bit("busy_o after run", busy, 1'b0);
    check_word("write count after run", word_t'(wr_log.size()), word_t'(count));
    check_bit("irq_o before clear", irq, 1'b1);
    host_write(CFG_IRQ_CLR, 32'd0);
    check_bit("irq_o after clear", irq, 1'b0);
    report_test("completion and interrupt", e);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    single_channel_run();
    multi_channel_run();
    dtype_stride_sweep();
    random_delay_run();
    completion_irq_run();
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/im2col_pkg.sv
rtl/im2col_cfg_regs.sv
rtl/im2col_desc_gen.sv
rtl/im2col_desc_fifo.sv
rtl/im2col_dma_loader.sv
rtl/im2col_reg_master.sv
rtl/im2col_spc.sv
test/tb_im2col_spc.sv

/* Makefile */
TOP = tb_im2col_spc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
